//--- common/cxp_macros.svh
/*
  cxp receive lane widths and APB register map
*/

`ifndef CXP_MACROS_SVH
`define CXP_MACROS_SVH

// ------------------------------
// datapath widths
`define CXP_SYM_W 10    // one 8b/10b symbol
`define CXP_CNT_W 16    // saturating link counters

// ------------------------------
// APB register offsets
`define CXP_REG_CTRL   8'h00  // bit 0 lsb_first, bit 1 relock pulse
`define CXP_REG_STATUS 8'h04  // bit 0 locked, bits 7:4 last control code
`define CXP_REG_IDLE   8'h08  // idle words seen
`define CXP_REG_WORDS  8'h0C  // data characters seen
`define CXP_REG_ERRORS 8'h10  // code errors seen

// counter registers clear on any write

`endif

//--- common/cxp_pkg.sv
/*
  cxp receive lane types
  symbol and word streams, aligner config and status, code classes
*/

`include "cxp_macros.svh"

package cxp_pkg;

  typedef enum logic {
    align_hunt,
    align_locked
  } cxp_align_state_e;

  // control code classes as seen by the link layer
  typedef enum logic [3:0] {
    code_data          = 4'd0,
    code_sop           = 4'd1,   // K27.7
    code_eop           = 4'd2,   // K29.7
    code_gpio          = 4'd3,   // K28.0
    code_io_ack        = 4'd4,   // K28.6
    code_align1        = 4'd5,   // K28.1
    code_align5        = 4'd6,   // K28.5
    code_trig_rise     = 4'd7,   // K28.2
    code_trig_fall     = 4'd8,   // K28.4
    code_stream_marker = 4'd9,   // K28.3
    code_invalid       = 4'd10
  } cxp_code_e;

  typedef struct packed {
    logic [`CXP_SYM_W-1:0] sym;  // abcdei_fghj with a at the top
    logic                  valid;
  } cxp_sym_t;

  typedef struct packed {
    logic [7:0] data;
    logic       is_k;
    cxp_code_e  code;
    logic       code_err;
    logic       valid;
  } cxp_word_t;

  typedef struct packed {
    logic lsb_first;
    logic relock;
  } cxp_align_cfg_t;

  typedef struct packed {
    logic locked;
    logic idle_found;
  } cxp_align_status_t;

endpackage

//--- cxp_bit_align/cxp_bit_align.sv
/*
  cxp bit aligner
  hunts for the idle word in the serial stream and frames 10-bit symbols
*/

`timescale 1ns/1ns
`include "cxp_macros.svh"

module cxp_bit_align
  import cxp_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  logic              serial_in,
  input  logic              bit_valid,
  input  cxp_align_cfg_t    cfg,
  output cxp_sym_t          sym,
  output cxp_align_status_t status
);

  localparam int WIN_W = 4 * `CXP_SYM_W;
  localparam int CNT_W = $clog2(`CXP_SYM_W);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`CXP_SYM_W - 1);

  // idle word symbols in the negative disparity form
  localparam logic [`CXP_SYM_W-1:0] K28_5 = 10'b001111_1010;
  localparam logic [`CXP_SYM_W-1:0] K28_1 = 10'b001111_1001;
  localparam logic [`CXP_SYM_W-1:0] D21_5 = 10'b101010_1010;

  logic [WIN_W-1:0]      shreg;
  logic [`CXP_SYM_W-1:0] slot [4];  // slot 0 is the oldest symbol
  logic [CNT_W-1:0]      bit_cnt;
  logic [CNT_W-1:0]      phase;
  logic                  take_q;    // a bit was shifted in on the last edge
  logic                  idle_match;
  logic                  idle_found_q;
  cxp_align_state_e      state;
  logic [`CXP_SYM_W-1:0] sym_q;
  logic                  sym_vld;

  // either disparity matches
  function automatic logic slot_match(input logic [`CXP_SYM_W-1:0] s,
                                      input logic [`CXP_SYM_W-1:0] k);
    return (s == k) || (s == ~k);
  endfunction

  // ------------------------------
  // serial shifter
  always_ff @(posedge clock) begin
    if (bit_valid) begin
      if (cfg.lsb_first)
        shreg <= {shreg[WIN_W-2:0], serial_in};  // first bit ends up at a
      else
        shreg <= {serial_in, shreg[WIN_W-1:1]};  // first bit ends up at j
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (cfg.lsb_first)
        slot[i] = shreg[WIN_W-1-i*`CXP_SYM_W -: `CXP_SYM_W];
      else
        slot[i] = shreg[i*`CXP_SYM_W +: `CXP_SYM_W];
    end
  end

  assign idle_match = take_q &&
                      slot_match(slot[0], K28_5) && slot_match(slot[1], K28_1) &&
                      slot_match(slot[2], K28_1) && slot_match(slot[3], D21_5);

  // ------------------------------
  // bit counter, phase and lock state
  always_ff @(posedge clock) begin
    if (reset) begin
      take_q       <= 1'b0;
      bit_cnt      <= '0;
      phase        <= '0;
      state        <= align_hunt;
      idle_found_q <= 1'b0;
      sym_vld      <= 1'b0;
    end else begin
      take_q       <= bit_valid;
      idle_found_q <= idle_match;
      if (bit_valid)
        bit_cnt <= (bit_cnt == LAST_BIT) ? '0 : bit_cnt + 1'b1;
      // emit every tenth bit counted in the locked phase
      sym_vld <= (state == align_locked) && take_q && (bit_cnt == phase);
      if (cfg.relock) begin
        state <= align_hunt;
      end else if (idle_match) begin
        state <= align_locked;
        phase <= bit_cnt;  // a new phase simply replaces the old one
      end
    end
  end

  always_ff @(posedge clock) begin
    if (take_q && (bit_cnt == phase))
      sym_q <= slot[3];  // newest symbol in the window
  end

  assign sym    = '{sym: sym_q, valid: sym_vld};
  assign status = '{locked: (state == align_locked), idle_found: idle_found_q};

endmodule

//--- hdl/cxp_8b10b_decode.sv
/*
  8b/10b symbol decoder
  table lookup of both sub-blocks plus control code classification
*/

`timescale 1ns/1ns

module cxp_8b10b_decode
  import cxp_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  cxp_sym_t  sym_in,
  output cxp_word_t word
);

  logic [12:0] k_res;  // {hit, class, byte}
  logic [5:0]  d6;     // {ok, EDCBA}
  logic [3:0]  d4;     // {ok, HGF}
  cxp_word_t   nxt;
  cxp_word_t   word_q;
  logic        vld_q;

  // ------------------------------
  // the twelve legal control codes, both disparities
  function automatic logic [12:0] dec_k(input logic [9:0] s);
    logic [12:0] r;
    case (s)
      10'b001111_0100, 10'b110000_1011: r = {1'b1, code_gpio, 8'h1C};
      10'b001111_1001, 10'b110000_0110: r = {1'b1, code_align1, 8'h3C};
      10'b001111_0101, 10'b110000_1010: r = {1'b1, code_trig_rise, 8'h5C};
      10'b001111_0011, 10'b110000_1100: r = {1'b1, code_stream_marker, 8'h7C};
      10'b001111_0010, 10'b110000_1101: r = {1'b1, code_trig_fall, 8'h9C};
      10'b001111_1010, 10'b110000_0101: r = {1'b1, code_align5, 8'hBC};
      10'b001111_0110, 10'b110000_1001: r = {1'b1, code_io_ack, 8'hDC};
      10'b110110_1000, 10'b001001_0111: r = {1'b1, code_sop, 8'hFB};
      10'b101110_1000, 10'b010001_0111: r = {1'b1, code_eop, 8'hFD};
      // legal but without a cxp meaning
      10'b001111_1000, 10'b110000_0111: r = {1'b1, code_invalid, 8'hFC};
      10'b111010_1000, 10'b000101_0111: r = {1'b1, code_invalid, 8'hF7};
      10'b011110_1000, 10'b100001_0111: r = {1'b1, code_invalid, 8'hFE};
      default:                          r = {1'b0, code_invalid, 8'h00};
    endcase
    return r;
  endfunction

  // 5b/6b sub-block, abcdei
  function automatic logic [5:0] dec_6b(input logic [5:0] c);
    logic [5:0] r;
    case (c)
      6'b100111, 6'b011000: r = {1'b1, 5'd0};
      6'b011101, 6'b100010: r = {1'b1, 5'd1};
      6'b101101, 6'b010010: r = {1'b1, 5'd2};
      6'b110001:            r = {1'b1, 5'd3};
      6'b110101, 6'b001010: r = {1'b1, 5'd4};
      6'b101001:            r = {1'b1, 5'd5};
      6'b011001:            r = {1'b1, 5'd6};
      6'b111000, 6'b000111: r = {1'b1, 5'd7};
      6'b111001, 6'b000110: r = {1'b1, 5'd8};
      6'b100101:            r = {1'b1, 5'd9};
      6'b010101:            r = {1'b1, 5'd10};
      6'b110100:            r = {1'b1, 5'd11};
      6'b001101:            r = {1'b1, 5'd12};
      6'b101100:            r = {1'b1, 5'd13};
      6'b011100:            r = {1'b1, 5'd14};
      6'b010111, 6'b101000: r = {1'b1, 5'd15};
      6'b011011, 6'b100100: r = {1'b1, 5'd16};
      6'b100011:            r = {1'b1, 5'd17};
      6'b010011:            r = {1'b1, 5'd18};
      6'b110010:            r = {1'b1, 5'd19};
      6'b001011:            r = {1'b1, 5'd20};
      6'b101010:            r = {1'b1, 5'd21};
      6'b011010:            r = {1'b1, 5'd22};
      6'b111010, 6'b000101: r = {1'b1, 5'd23};
      6'b110011, 6'b001100: r = {1'b1, 5'd24};
      6'b100110:            r = {1'b1, 5'd25};
      6'b010110:            r = {1'b1, 5'd26};
      6'b110110, 6'b001001: r = {1'b1, 5'd27};
      6'b001110:            r = {1'b1, 5'd28};
      6'b101110, 6'b010001: r = {1'b1, 5'd29};
      6'b011110, 6'b100001: r = {1'b1, 5'd30};
      6'b101011, 6'b010100: r = {1'b1, 5'd31};
      default:              r = 6'd0;
    endcase
    return r;
  endfunction

  // 3b/4b sub-block, fghj
  function automatic logic [3:0] dec_4b(input logic [3:0] c);
    logic [3:0] r;
    case (c)
      4'b1011, 4'b0100:                   r = {1'b1, 3'd0};
      4'b1001:                            r = {1'b1, 3'd1};
      4'b0101:                            r = {1'b1, 3'd2};
      4'b1100, 4'b0011:                   r = {1'b1, 3'd3};
      4'b1101, 4'b0010:                   r = {1'b1, 3'd4};
      4'b1010:                            r = {1'b1, 3'd5};
      4'b0110:                            r = {1'b1, 3'd6};
      4'b1110, 4'b0001, 4'b0111, 4'b1000: r = {1'b1, 3'd7};  // primary and alternate
      default:                            r = 4'd0;
    endcase
    return r;
  endfunction

  // ------------------------------
  always_comb begin
    k_res = dec_k(sym_in.sym);
    d6    = dec_6b(sym_in.sym[9:4]);
    d4    = dec_4b(sym_in.sym[3:0]);
    nxt.valid = sym_in.valid;
    if (k_res[12]) begin
      nxt.data     = k_res[7:0];
      nxt.is_k     = 1'b1;
      nxt.code     = cxp_code_e'(k_res[11:8]);
      nxt.code_err = 1'b0;
    end else if (d6[5] && d4[3]) begin
      nxt.data     = {d4[2:0], d6[4:0]};
      nxt.is_k     = 1'b0;
      nxt.code     = code_data;
      nxt.code_err = 1'b0;
    end else begin
      nxt.data     = 8'h00;  // not in either table
      nxt.is_k     = 1'b0;
      nxt.code     = code_invalid;
      nxt.code_err = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (sym_in.valid)
      word_q <= nxt;
  end

  always_ff @(posedge clock) begin
    if (reset)
      vld_q <= 1'b0;
    else
      vld_q <= sym_in.valid;
  end

  always_comb begin
    word       = word_q;
    word.valid = vld_q;
  end

endmodule

//--- hdl/cxp_link_monitor.sv
/*
  cxp link monitor
  output register, link counters and APB configuration slave
*/

`timescale 1ns/1ns
`include "cxp_macros.svh"

module cxp_link_monitor
  import cxp_pkg::*;
(
  input  logic              clock,
  input  logic              reset,
  input  cxp_word_t         word_in,
  input  cxp_align_status_t status,
  output cxp_align_cfg_t    cfg,
  output cxp_word_t         rx_word,
  output logic              locked,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [7:0]        paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr
);

  localparam int PAD_W = 32 - `CXP_CNT_W;

  cxp_word_t             rx_q;
  logic                  rx_vld;
  logic                  lsb_first_q;
  logic                  relock_q;
  cxp_code_e             last_code;
  logic [`CXP_CNT_W-1:0] idle_cnt;
  logic [`CXP_CNT_W-1:0] words_cnt;
  logic [`CXP_CNT_W-1:0] err_cnt;
  logic                  wr_en;

  function automatic logic [`CXP_CNT_W-1:0] sat_inc(input logic [`CXP_CNT_W-1:0] c,
                                                   input logic en);
    if (en && !(&c))
      return c + 1'b1;
    return c;  // holds at all ones
  endfunction

  // ------------------------------
  // decoded stream to the outputs
  always_ff @(posedge clock) begin
    rx_q <= word_in;
  end

  always_comb begin
    rx_word       = rx_q;
    rx_word.valid = rx_vld;
  end

  assign wr_en = psel && penable && pwrite;  // access edge

  // ------------------------------
  // configuration and counters
  always_ff @(posedge clock) begin
    if (reset) begin
      rx_vld      <= 1'b0;
      lsb_first_q <= 1'b1;
      relock_q    <= 1'b0;
      last_code   <= code_data;
      idle_cnt    <= '0;
      words_cnt   <= '0;
      err_cnt     <= '0;
    end else begin
      rx_vld   <= word_in.valid;
      relock_q <= wr_en && (paddr == `CXP_REG_CTRL) && pwdata[1];
      if (wr_en && (paddr == `CXP_REG_CTRL))
        lsb_first_q <= pwdata[0];
      if (word_in.valid && word_in.is_k)
        last_code <= word_in.code;
      // a write clears the counter and wins over a count
      if (wr_en && (paddr == `CXP_REG_IDLE))
        idle_cnt <= '0;
      else
        idle_cnt <= sat_inc(idle_cnt, status.idle_found);
      if (wr_en && (paddr == `CXP_REG_WORDS))
        words_cnt <= '0;
      else
        words_cnt <= sat_inc(words_cnt, word_in.valid && !word_in.is_k && !word_in.code_err);
      if (wr_en && (paddr == `CXP_REG_ERRORS))
        err_cnt <= '0;
      else
        err_cnt <= sat_inc(err_cnt, word_in.valid && word_in.code_err);
    end
  end

  // ------------------------------
  // APB read mux
  always_comb begin
    prdata = 32'd0;
    case (paddr)
      `CXP_REG_CTRL:   prdata = {31'd0, lsb_first_q};  // relock reads back 0
      `CXP_REG_STATUS: prdata = {24'd0, last_code, 3'd0, status.locked};
      `CXP_REG_IDLE:   prdata = {{PAD_W{1'b0}}, idle_cnt};
      `CXP_REG_WORDS:  prdata = {{PAD_W{1'b0}}, words_cnt};
      `CXP_REG_ERRORS: prdata = {{PAD_W{1'b0}}, err_cnt};
      default:         prdata = 32'd0;
    endcase
  end

  assign pready  = 1'b1;
  assign pslverr = 1'b0;
  assign cfg     = '{lsb_first: lsb_first_q, relock: relock_q};
  assign locked  = status.locked;

endmodule

//--- hdl/cxp_rx_top.sv
/*
  cxp receive lane front end
*/

`timescale 1ns/1ns

module cxp_rx_top
  import cxp_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        serial_in,
  input  logic        bit_valid,
  output cxp_word_t   rx_word,
  output logic        locked,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  cxp_sym_t          sym;           // framed symbols
  cxp_word_t         word;          // decoded characters
  cxp_align_status_t align_status;
  cxp_align_cfg_t    align_cfg;

  cxp_bit_align cxp_bit_align_inst (
    .clock     (clock),
    .reset     (reset),
    .serial_in (serial_in),
    .bit_valid (bit_valid),
    .cfg       (align_cfg),
    .sym       (sym),
    .status    (align_status)
  );

  cxp_8b10b_decode cxp_8b10b_decode_inst (
    .clock  (clock),
    .reset  (reset),
    .sym_in (sym),
    .word   (word)
  );

  cxp_link_monitor cxp_link_monitor_inst (
    .clock   (clock),
    .reset   (reset),
    .word_in (word),
    .status  (align_status),
    .cfg     (align_cfg),
    .rx_word (rx_word),
    .locked  (locked),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

endmodule

//--- verif/cxp_rx_checker.sv
/*
  cxp receive lane checker
  compares rx_word against the queue of expected words
*/

`timescale 1ns/1ns

module cxp_rx_checker
  import cxp_pkg::*;
(
  input logic      clock,
  input cxp_word_t rx_word
);

  cxp_word_t expected_q[$];  // oldest expected word at the front
  int        error_count = 0;
  int        checked     = 0;

  task automatic push_expected(input cxp_word_t w);
    expected_q.push_back(w);
  endtask

  function automatic int pending();
    return expected_q.size();
  endfunction

  // ------------------------------
  // compare each valid word in order
  always @(posedge clock) begin : compare
    cxp_word_t exp_w;
    if (rx_word.valid) begin
      if (expected_q.size() == 0) begin
        $display("a word appeared on rx_word with none expected, data %h", rx_word.data);
        error_count++;
      end else begin
        exp_w = expected_q.pop_front();
        checked++;
        if (rx_word.data !== exp_w.data) begin
          $display("error: rx_word.data got %h expected %h", rx_word.data, exp_w.data);
          error_count++;
        end
        if (rx_word.is_k !== exp_w.is_k) begin
          $display("error: rx_word.is_k got %h expected %h", rx_word.is_k, exp_w.is_k);
          error_count++;
        end
        if (rx_word.code !== exp_w.code) begin
          $display("error: rx_word.code got %h expected %h", rx_word.code, exp_w.code);
          error_count++;
        end
        if (rx_word.code_err !== exp_w.code_err) begin
          $display("error: rx_word.code_err got %h expected %h",
                   rx_word.code_err, exp_w.code_err);
          error_count++;
        end
      end
    end
  end

endmodule

//--- verif/cxp_rx_tb.sv
/*
  cxp receive lane testbench
  serial 8b/10b stimulus, APB register checks
*/

`timescale 1ns/1ns
`include "cxp_macros.svh"

module cxp_rx_tb
  import cxp_pkg::*;
();

  logic        clock;
  logic        reset;
  logic        serial_in;
  logic        bit_valid;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        locked;
  cxp_word_t   rx_word;

  logic [31:0] lfsr = 32'h2963_46b8;
  logic        rd;         // encoder running disparity, 1 is positive
  logic        lsb_first;  // serial order, a first when set
  logic        track;      // push expected words once lock is due
  logic        gap_en;
  int          errors;
  int          test_no;
  int          tests_failed;
  int          err_base;
  logic [31:0] rdata;

  always #20 clock = ~clock;

  cxp_rx_top cxp_rx_top_inst (
    .clock(clock), .reset(reset), .serial_in(serial_in), .bit_valid(bit_valid),
    .rx_word(rx_word), .locked(locked), .psel(psel), .penable(penable),
    .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
    .pready(pready), .pslverr(pslverr)
  );

  cxp_rx_checker cxp_rx_checker_inst (.clock(clock), .rx_word(rx_word));

  // ------------------------------
  // random source and reference model
  function automatic int unsigned rand_bits(input int n);
    int unsigned r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // 5b/6b codes in the negative disparity form, abcdei
  function automatic logic [5:0] enc_6b(input logic [4:0] x);
    logic [5:0] t [32];
    t = '{6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001,
          6'b011001, 6'b111000, 6'b111001, 6'b100101, 6'b010101, 6'b110100,
          6'b001101, 6'b101100, 6'b011100, 6'b010111, 6'b011011, 6'b100011,
          6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
          6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110,
          6'b011110, 6'b101011};
    return t[x];
  endfunction

  function automatic logic [9:0] encode_sym(input logic [7:0] b, input logic k,
                                            input logic rd_in);
    logic [3:0] d4 [8];
    logic [3:0] k4 [8];
    logic [5:0] s6;
    logic [3:0] s4;
    logic       rd1;
    d4 = '{4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};
    k4 = '{4'b0100, 4'b1001, 4'b0101, 4'b0011, 4'b0010, 4'b1010, 4'b0110, 4'b1000};
    if (k) begin  // control symbols flip as a whole
      s6 = (b[4:0] == 5'd28) ? 6'b001111 : enc_6b(b[4:0]);
      s4 = (b[4:0] == 5'd28) ? k4[b[7:5]] : 4'b1000;
      return rd_in ? ~{s6, s4} : {s6, s4};
    end
    s6 = enc_6b(b[4:0]);
    if (rd_in && (($countones(s6) != 3) || b[4:0] == 5'd7))
      s6 = ~s6;
    rd1 = rd_in ^ ($countones(s6) != 3);
    s4 = d4[b[7:5]];
    if (b[7:5] == 3'd7 && ((!rd1 && (b[4:0] inside {17, 18, 20})) ||
                           (rd1 && (b[4:0] inside {11, 13, 14}))))
      s4 = 4'b0111;  // alternate D.x.7 avoids a run of five
    if (rd1 && (($countones(s4) != 2) || b[7:5] == 3'd3))
      s4 = ~s4;
    return {s6, s4};
  endfunction

  function automatic cxp_word_t expected_word(input logic [7:0] b, input logic k);
    cxp_code_e c;
    c = code_data;
    if (k) begin
      case (b)
        8'hFB:   c = code_sop;
        8'hFD:   c = code_eop;
        8'h1C:   c = code_gpio;
        8'hDC:   c = code_io_ack;
        8'h3C:   c = code_align1;
        8'hBC:   c = code_align5;
        8'h5C:   c = code_trig_rise;
        8'h9C:   c = code_trig_fall;
        8'h7C:   c = code_stream_marker;
        default: c = code_invalid;
      endcase
    end
    return '{data: b, is_k: k, code: c, code_err: 1'b0, valid: 1'b1};
  endfunction

  // ------------------------------
  // serial stimulus
  task automatic send_bit(input logic b);
    if (gap_en && rand_bits(2) == 0) begin
      @(negedge clock);
      bit_valid = 1'b0;  // idle cycle on the line
    end
    @(negedge clock);
    serial_in = b;
    bit_valid = 1'b1;
  endtask

  task automatic send_sym(input logic [9:0] s);
    for (int i = 0; i < 10; i++)
      send_bit(lsb_first ? s[9-i] : s[i]);
  endtask

  task automatic send_char(input logic [7:0] b, input logic k);
    logic [9:0] s;
    s  = encode_sym(b, k, rd);
    rd = rd ^ ($countones(s) != 5);
    if (track)
      cxp_rx_checker_inst.push_expected(expected_word(b, k));
    send_sym(s);
  endtask

  task automatic send_idle();
    send_char(8'hBC, 1'b1);
    send_char(8'h3C, 1'b1);
    send_char(8'h3C, 1'b1);
    send_char(8'hB5, 1'b0);  // D21.5
    track = 1'b1;
  endtask

  task automatic send_junk();
    int n;
    n = rand_bits(4) % 10;
    repeat (n) send_bit(1'(rand_bits(1)));
  endtask

  task automatic line_idle();
    @(negedge clock);
    bit_valid = 1'b0;
  endtask

  // ------------------------------
  // APB master and checks
  task automatic apb_access(input logic [7:0] addr, input logic wr,
                            input logic [31:0] wdata, output logic [31:0] data);
    int n;
    @(negedge clock);
    psel = 1'b1;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    @(negedge clock);
    penable = 1'b1;
    n = 0;
    while (!pready && n < 16) begin
      @(negedge clock);
      n++;
    end
    if (!pready) begin
      $display("APB slave never raised pready at address %h", addr);
      errors++;
    end
    #5 data = prdata;
    if (pslverr !== 1'b0) begin
      $display("error: pslverr got %h expected %h", pslverr, 1'b0);
      errors++;
    end
    @(negedge clock);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_access(addr, 1'b1, data, unused);
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_reg(input string name, input logic [7:0] addr,
                           input logic [31:0] exp);
    apb_access(addr, 1'b0, 32'd0, rdata);
    check_val(name, rdata, exp);
  endtask

  task automatic wait_drain();
    int n;
    line_idle();
    n = 0;
    while (cxp_rx_checker_inst.pending() > 0 && n < 2000) begin
      @(negedge clock);
      n++;
    end
    if (cxp_rx_checker_inst.pending() > 0) begin
      $display("timed out with %0d expected words missing from rx_word",
               cxp_rx_checker_inst.pending());
      errors++;
    end
    repeat (2) @(negedge clock);  // counters settle
  endtask

  task automatic end_test(input string name);
    int now;
    now = errors + cxp_rx_checker_inst.error_count;
    test_no++;
    if (now != err_base)
      tests_failed++;
    $display("test %0d %s: %s", test_no, name, (now == err_base) ? "ok" : "FAILED");
    err_base = now;
  endtask

  task automatic lock_and_stream(input string tag);
    int n_idle;
    send_junk();
    n_idle = 2 + rand_bits(2) % 3;
    repeat (n_idle) send_idle();
    wait_drain();
    check_val("locked", 32'(locked), 32'd1);
    // idle words after lock leave K28.1 as the last control code
    check_reg("STATUS.locked", `CXP_REG_STATUS, {24'd0, code_align1, 4'd1});
    check_reg("IDLE", `CXP_REG_IDLE, n_idle);
    end_test({tag, " lock on idle words"});
    apb_write(`CXP_REG_WORDS, 32'd0);
    gap_en = 1'b1;
    for (int i = 0; i < 24; i++)
      send_char(8'(rand_bits(8)), 1'b0);
    gap_en = 1'b0;
    wait_drain();
    check_reg("WORDS", `CXP_REG_WORDS, 24);
    end_test({tag, " random data with gaps"});
  endtask

  // ------------------------------
  initial begin
    clock = 0;
    reset = 1;
    serial_in = 0;
    bit_valid = 0;
    psel = 0;
    penable = 0;
    pwrite = 0;
    paddr = 0;
    pwdata = 0;
    rd = 0;
    lsb_first = 1;
    track = 0;
    gap_en = 0;
    errors = 0;
    test_no = 0;
    tests_failed = 0;
    err_base = 0;
    repeat (4) @(negedge clock);
    reset = 0;

    check_val("rx_word.valid", 32'(rx_word.valid), 32'd0);
    check_val("locked", 32'(locked), 32'd0);
    check_reg("IDLE", `CXP_REG_IDLE, 0);
    check_reg("WORDS", `CXP_REG_WORDS, 0);
    check_reg("ERRORS", `CXP_REG_ERRORS, 0);
    end_test("reset values");

    lock_and_stream("lsb first");

    // align1 ahead of align5 so no idle word forms
    send_char(8'hFB, 1'b1);
    send_char(8'hFD, 1'b1);
    send_char(8'h1C, 1'b1);
    send_char(8'hDC, 1'b1);
    send_char(8'h3C, 1'b1);
    send_char(8'hBC, 1'b1);
    send_char(8'h5C, 1'b1);
    send_char(8'h9C, 1'b1);
    send_char(8'h7C, 1'b1);
    wait_drain();
    check_reg("STATUS", `CXP_REG_STATUS, {24'd0, code_stream_marker, 4'd1});
    end_test("control codes");

    track = 1'b0;
    apb_write(`CXP_REG_CTRL, 32'h2);  // msb first plus relock
    lsb_first = 1'b0;
    repeat (2) @(negedge clock);
    check_val("locked", 32'(locked), 32'd0);
    apb_write(`CXP_REG_IDLE, 32'd0);
    lock_and_stream("msb first");

    send_sym(10'b0000000000);
    cxp_rx_checker_inst.push_expected('{data: 8'h00, is_k: 1'b0, code: code_invalid,
                                        code_err: 1'b1, valid: 1'b1});
    wait_drain();
    check_reg("ERRORS", `CXP_REG_ERRORS, 1);
    apb_write(`CXP_REG_ERRORS, 32'd0);
    check_reg("ERRORS", `CXP_REG_ERRORS, 0);
    end_test("invalid symbol");

    $display("tests %0d, failed %0d, words checked %0d, errors %0d", test_no,
             tests_failed, cxp_rx_checker_inst.checked, err_base);
    if (err_base == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+common
common/cxp_pkg.sv
cxp_bit_align/cxp_bit_align.sv
hdl/cxp_8b10b_decode.sv
hdl/cxp_link_monitor.sv
hdl/cxp_rx_top.sv
verif/cxp_rx_checker.sv
verif/cxp_rx_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cxp_rx_tb
RTL_TOP   ?= cxp_rx_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
